/* all.f */
+incdir+logic
logic/regex_pkg.sv
logic/dual_width_bram.sv
logic/regex_cmd_ctrl.sv
logic/regex_coprocessor.sv
logic/regex_accel_top.sv
dv/regex_accel_tb.sv

/* Bender.yml */
package:
  name: regex_accel

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/regex_pkg.sv
      - logic/dual_width_bram.sv
      - logic/regex_cmd_ctrl.sv
      - logic/regex_coprocessor.sv
      - logic/regex_accel_top.sv

  - target: test
    include_dirs:
      - logic
    files:
      - dv/regex_accel_tb.sv

/* dv/regex_accel_tb.sv */
// Testbench for the regex accelerator top level.
// Drives host commands as levels and checks memory, match status, the
// elapsed counter and soft reset against a model of the matcher.

`include "regex_config.svh"

module regex_accel_tb;

    localparam int CLK_HALF    = 50;
    localparam int DRIVE_DELAY = 10;
    localparam int WAIT_LIMIT  = 2000;
    localparam int TEXT_BASE   = 512;
    localparam int PC_W        = `REGEX_PC_WIDTH;

    logic                        clk;
    logic                        rst_master;
    regex_pkg::host_regs_t       host;
    regex_pkg::regex_status_e    status;
    logic [`REGEX_REG_WIDTH-1:0] data_out;

    // host copy of memory with one entry per write address
    logic [31:0] shadow [2 ** `REGEX_MEM_WR_ADDR_WIDTH];
    logic [31:0] prog_buf [64];

    logic [31:0] exp_q [$];
    logic [31:0] got_q [$];
    string       msg_q [$];
    logic [31:0] cmp_exp;
    logic [31:0] cmp_got;
    string       cmp_msg;

    int     check_count    = 0;
    int     mismatch_count = 0;
    int     timeout_count  = 0;
    integer seed;

    regex_accel_top regex_accel_top_inst (
        .clk        (clk),
        .rst_master (rst_master),
        .host       (host),
        .status     (status),
        .data_out   (data_out)
    );

    always #CLK_HALF clk = ~clk;

    // drain queued checks on each falling edge
    always @(negedge clk)
    begin
        while (exp_q.size() > 0)
        begin
            cmp_exp = exp_q.pop_front();
            cmp_got = got_q.pop_front();
            cmp_msg = msg_q.pop_front();
            assert (cmp_got === cmp_exp)
            else
            begin
                $display("MISMATCH at time %0t: %s, expected %0h, got %0h",
                         $time, cmp_msg, cmp_exp, cmp_got);
                mismatch_count++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic regex_pkg::regex_status_e regex_expect(input int start_ptr,
                                                              input int end_ptr);
        int                       pc;
        int                       ptr;
        int                       steps;
        logic [31:0]              instr;
        logic [7:0]               text_ch;
        regex_pkg::regex_status_e res;

        pc  = 0;
        ptr = start_ptr;
        res = regex_pkg::STATUS_RUNNING;
        for (steps = 0; steps < 2 ** PC_W && res == regex_pkg::STATUS_RUNNING; steps++)
        begin
            instr   = shadow[2 * pc];
            text_ch = shadow[ptr / 4][8 * (ptr % 4) +: 8];
            if (instr[31:24] == regex_pkg::OP_ACCEPT)
                res = (ptr == end_ptr) ? regex_pkg::STATUS_ACCEPTED : regex_pkg::STATUS_REJECTED;
            else if (instr[31:24] != regex_pkg::OP_CHAR && instr[31:24] != regex_pkg::OP_ANY)
                res = regex_pkg::STATUS_ERROR;
            else if (ptr == end_ptr)
                res = regex_pkg::STATUS_REJECTED;
            else if (instr[31:24] == regex_pkg::OP_CHAR && text_ch != instr[7:0])
                res = regex_pkg::STATUS_REJECTED;
            // stepping past the last instruction word
            else if (pc == 2 ** PC_W - 1)
                res = regex_pkg::STATUS_ERROR;
            else
            begin
                pc++;
                ptr++;
            end
        end
        return res;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // host tasks entered and left just after a rising edge
    //////////////////////////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic push_check(input logic [31:0] expected, input logic [31:0] actual,
                              input string msg);
        exp_q.push_back(expected);
        got_q.push_back(actual);
        msg_q.push_back(msg);
        check_count++;
    endtask

    task automatic send_cmd(input regex_pkg::regex_cmd_e cmd);
        host.cmd = cmd;
        next_cycle();
        host.cmd = regex_pkg::CMD_NOP;
    endtask

    task automatic write_word(input int addr, input logic [31:0] data);
        host.cmd     = regex_pkg::CMD_WRITE;
        host.address = addr;
        host.data_in = data;
        shadow[addr] = data;
        next_cycle();
        host.cmd = regex_pkg::CMD_NOP;
    endtask

    // read data valid in the second cycle of the command
    task automatic read_word(input int addr, output logic [31:0] data);
        host.cmd     = regex_pkg::CMD_READ;
        host.address = addr;
        next_cycle();
        @(negedge clk);
        data = data_out;
        next_cycle();
        host.cmd = regex_pkg::CMD_NOP;
    endtask

    task automatic read_elapsed(output logic [31:0] value);
        host.cmd = regex_pkg::CMD_READ_ELAPSED_CLOCK;
        @(negedge clk);
        value = data_out;
        next_cycle();
        host.cmd = regex_pkg::CMD_NOP;
    endtask

    task automatic set_text_byte(input int p, input logic [7:0] b);
        shadow[p / 4][8 * (p % 4) +: 8] = b;
    endtask

    // instruction i goes to the low half of read word i
    task automatic load_program(input int len);
        int i;
        for (i = 0; i < len; i++)
        begin
            write_word(2 * i, prog_buf[i]);
        end
    endtask

    task automatic load_text(input int first, input int last);
        int w;
        for (w = first / 4; w <= last / 4; w++)
        begin
            write_word(w, shadow[w]);
        end
    endtask

    task automatic start_run(input int start_ptr, input int end_ptr);
        int   i;
        logic seen;
        host.start_ptr = start_ptr;
        host.end_ptr   = end_ptr;
        host.cmd       = regex_pkg::CMD_START;
        seen = 1'b0;
        for (i = 0; i < WAIT_LIMIT && !seen; i++)
        begin
            @(negedge clk);
            seen = (status == regex_pkg::STATUS_RUNNING);
            next_cycle();
        end
        host.cmd = regex_pkg::CMD_NOP;
        assert (seen)
        else
        begin
            $display("timeout: status did not become running within %0d cycles", WAIT_LIMIT);
            timeout_count++;
        end
    endtask

    task automatic wait_finish(output regex_pkg::regex_status_e final_status);
        int   i;
        logic done;
        done = 1'b0;
        for (i = 0; i < WAIT_LIMIT && !done; i++)
        begin
            @(negedge clk);
            done = (status != regex_pkg::STATUS_RUNNING) && (status != regex_pkg::STATUS_IDLE);
            next_cycle();
        end
        final_status = status;
        assert (done)
        else
        begin
            $display("timeout: the run did not finish within %0d cycles", WAIT_LIMIT);
            timeout_count++;
        end
    endtask

    task automatic run(input int start_ptr, input int end_ptr,
                       output regex_pkg::regex_status_e final_status);
        send_cmd(regex_pkg::CMD_RESTART);
        start_run(start_ptr, end_ptr);
        wait_finish(final_status);
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial
    begin : stimulus
        int                       trial;
        int                       i;
        int                       len;
        int                       start;
        int                       stop;
        int                       flip;
        int                       addrs [16];
        logic [31:0]              r;
        logic [31:0]              v;
        logic [31:0]              e1;
        logic [31:0]              e2;
        logic [7:0]               ch;
        logic [7:0]               b;
        regex_pkg::regex_status_e got;

        seed       = 32'h96a8;
        clk        = 1'b0;
        rst_master = 1'b1;
        host       = '0;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        rst_master = 1'b0;
        push_check(regex_pkg::STATUS_IDLE, status, "status after reset");
        read_elapsed(v);
        push_check(32'd0, v, "elapsed after reset");

        // memory round trip over both lanes
        for (i = 0; i < 16; i++)
        begin
            r        = $random(seed);
            addrs[i] = {r[9:1], i[0]};
            write_word(addrs[i], $random(seed));
        end
        for (i = 0; i < 16; i++)
        begin
            read_word(addrs[i], v);
            push_check(shadow[addrs[i]], v, "memory read back");
        end

        // literal and wildcard programs on four text variants
        for (trial = 0; trial < 24; trial++)
        begin
            r     = $random(seed);
            len   = 1 + r[2:0];
            start = TEXT_BASE + r[6:3];
            flip  = (trial % 4 == 1) ? (r[15:8] % len) : -1;
            for (i = 0; i < len; i++)
            begin
                r  = $random(seed);
                ch = 8'h61 + r[15:8] % 26;
                b  = r[0] ? ch : r[23:16];
                prog_buf[i] = r[0] ? {regex_pkg::OP_CHAR, 16'h0000, ch}
                                   : {regex_pkg::OP_ANY, 24'h000000};
                set_text_byte(start + i, (i == flip) ? (b ^ 8'h20) : b);
            end
            prog_buf[len] = {regex_pkg::OP_ACCEPT, 24'h000000};
            set_text_byte(start + len, r[31:24]);
            set_text_byte(start + len + 1, r[30:23]);
            case (trial % 4)
                2:       stop = start + len - 1;
                3:       stop = start + len + 2;
                default: stop = start + len;
            endcase
            load_program(len + 1);
            load_text(start, start + len + 2);
            run(start, stop, got);
            push_check(regex_expect(start, stop), got, "match status");
        end

        // undefined opcode
        prog_buf[0] = {8'h07, 16'h0000, 8'h61};
        load_program(1);
        run(TEXT_BASE, TEXT_BASE + 1, got);
        push_check(regex_expect(TEXT_BASE, TEXT_BASE + 1), got, "undefined opcode status");
        push_check(regex_pkg::STATUS_ERROR, got, "error status");

        // start ignored until restart
        host.start_ptr = TEXT_BASE;
        host.end_ptr   = TEXT_BASE + 2;
        host.cmd       = regex_pkg::CMD_START;
        for (i = 0; i < 3; i++)
        begin
            next_cycle();
            push_check(regex_pkg::STATUS_ERROR, status, "start while finished");
        end
        host.cmd = regex_pkg::CMD_NOP;
        send_cmd(regex_pkg::CMD_RESTART);
        push_check(regex_pkg::STATUS_IDLE, status, "restart to idle");
        prog_buf[0] = {regex_pkg::OP_CHAR, 16'h0000, 8'h6f};
        prog_buf[1] = {regex_pkg::OP_CHAR, 16'h0000, 8'h6b};
        prog_buf[2] = {regex_pkg::OP_ACCEPT, 24'h000000};
        set_text_byte(TEXT_BASE, 8'h6f);
        set_text_byte(TEXT_BASE + 1, 8'h6b);
        load_program(3);
        load_text(TEXT_BASE, TEXT_BASE + 1);
        run(TEXT_BASE, TEXT_BASE + 2, got);
        push_check(regex_expect(TEXT_BASE, TEXT_BASE + 2), got, "second run status");

        // elapsed counter
        read_elapsed(e1);
        push_check(32'd1, e1 != 0, "elapsed nonzero after run");
        read_elapsed(e2);
        push_check(e1, e2, "elapsed stable while finished");
        send_cmd(regex_pkg::CMD_RESET);
        read_elapsed(v);
        push_check(32'd0, v, "elapsed after soft reset");
        push_check(regex_pkg::STATUS_IDLE, status, "status after soft reset");

        // soft reset in the middle of a long run
        for (i = 0; i < 48; i++)
        begin
            r           = $random(seed);
            prog_buf[i] = {regex_pkg::OP_ANY, 24'h000000};
            set_text_byte(TEXT_BASE + i, r[7:0]);
        end
        prog_buf[48] = {regex_pkg::OP_ACCEPT, 24'h000000};
        load_program(49);
        load_text(TEXT_BASE, TEXT_BASE + 47);
        send_cmd(regex_pkg::CMD_RESTART);
        start_run(TEXT_BASE, TEXT_BASE + 48);
        repeat (4) next_cycle();
        push_check(regex_pkg::STATUS_RUNNING, status, "still running before reset");
        send_cmd(regex_pkg::CMD_RESET);
        push_check(regex_pkg::STATUS_IDLE, status, "idle after reset while running");
        read_word(0, v);
        push_check(shadow[0], v, "program kept over soft reset");
        read_word(TEXT_BASE / 4 + 1, v);
        push_check(shadow[TEXT_BASE / 4 + 1], v, "text kept over soft reset");
        run(TEXT_BASE, TEXT_BASE + 48, got);
        push_check(regex_expect(TEXT_BASE, TEXT_BASE + 48), got, "run after soft reset");

        // let the compare process drain
        next_cycle();
        next_cycle();
        $display("summary: %0d checks, %0d mismatches, %0d timeouts",
                 check_count, mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* logic/regex_accel_top.sv */
// Top level of the regex accelerator.
// The host drives the register struct as levels and reads back the status
// and data_out; the controller, shared memory and coprocessor sit below.

`include "regex_config.svh"

module regex_accel_top
(
    input  logic                        clk,
    input  logic                        rst_master,
    input  regex_pkg::host_regs_t       host,
    output regex_pkg::regex_status_e    status,
    output logic [`REGEX_REG_WIDTH-1:0] data_out
);

    regex_pkg::mem_wr_t                  mem_wr;
    regex_pkg::mem_rd_t                  mem_rd;
    logic [`REGEX_MEM_RD_WIDTH-1:0]      rd_data;
    logic                                start_valid;
    logic                                start_ready;
    logic                                mem_req_valid;
    logic [`REGEX_MEM_RD_ADDR_WIDTH-1:0] mem_req_addr;
    logic                                mem_req_ready;
    regex_pkg::match_result_t            result;
    logic                                core_rst;

    regex_cmd_ctrl regex_cmd_ctrl_inst (
        .clk           (clk),
        .rst_master    (rst_master),
        .host          (host),
        .rd_data       (rd_data),
        .mem_wr        (mem_wr),
        .mem_rd        (mem_rd),
        .start_valid   (start_valid),
        .start_ready   (start_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_ready (mem_req_ready),
        .result        (result),
        .status        (status),
        .data_out      (data_out),
        .core_rst      (core_rst)
    );

    dual_width_bram dual_width_bram_inst (
        .clk     (clk),
        .wr      (mem_wr),
        .rd      (mem_rd),
        .rd_data (rd_data)
    );

    regex_coprocessor regex_coprocessor_inst (
        .clk           (clk),
        .core_rst      (core_rst),
        .start_valid   (start_valid),
        .start_ready   (start_ready),
        .start_ptr     (host.start_ptr[`REGEX_PTR_WIDTH-1:0]),
        .end_ptr       (host.end_ptr[`REGEX_PTR_WIDTH-1:0]),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_ready (mem_req_ready),
        .rd_data       (rd_data),
        .result        (result)
    );

endmodule

/* logic/regex_coprocessor.sv */
// Single-thread anchored regex matcher.
// Fetches one instruction per step from memory word pc, and for OP_CHAR the
// text byte at the pointer, then reports accept, reject or error with a
// one-cycle done pulse.

`include "regex_config.svh"

module regex_coprocessor
(
    input  logic                                clk,
    input  logic                                core_rst,
    input  logic                                start_valid,
    output logic                                start_ready,
    input  logic [`REGEX_PTR_WIDTH-1:0]         start_ptr,
    input  logic [`REGEX_PTR_WIDTH-1:0]         end_ptr,
    output logic                                mem_req_valid,
    output logic [`REGEX_MEM_RD_ADDR_WIDTH-1:0] mem_req_addr,
    input  logic                                mem_req_ready,
    input  logic [`REGEX_MEM_RD_WIDTH-1:0]      rd_data,
    output regex_pkg::match_result_t            result
);

    // byte lane bits inside one read word
    localparam int LANE_BITS = $clog2(`REGEX_MEM_RD_WIDTH / `REGEX_CHAR_WIDTH);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH_INSTR,
        ST_WAIT_INSTR,
        ST_FETCH_CHAR,
        ST_WAIT_CHAR,
        ST_FINISH
    } state_e;

    state_e                         state;
    state_e                         state_next;
    logic [`REGEX_PC_WIDTH-1:0]     pc;
    logic [`REGEX_PC_WIDTH-1:0]     pc_next;
    logic [`REGEX_PTR_WIDTH-1:0]    ptr;
    logic [`REGEX_PTR_WIDTH-1:0]    ptr_next;
    logic                           accept_q;
    logic                           accept_next;
    logic                           error_q;
    logic                           error_next;
    logic [`REGEX_PTR_WIDTH-1:0]    end_q;
    logic [`REGEX_CHAR_WIDTH-1:0]   ch_q;

    regex_pkg::regex_op_e           op;
    logic [`REGEX_CHAR_WIDTH-1:0]   instr_ch;
    logic [`REGEX_CHAR_WIDTH-1:0]   text_ch;
    logic                           at_end;

    // instruction lives in the low 32 bits of the word
    assign op       = regex_pkg::regex_op_e'(rd_data[31:24]);
    assign instr_ch = rd_data[`REGEX_CHAR_WIDTH-1:0];
    assign text_ch  = rd_data[ptr[LANE_BITS-1:0]*`REGEX_CHAR_WIDTH +: `REGEX_CHAR_WIDTH];
    assign at_end   = (ptr == end_q);

    //////////////////////////////////////////////////////////////////////
    // state and control registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (core_rst)
        begin
            state    <= ST_IDLE;
            pc       <= '0;
            ptr      <= '0;
            accept_q <= 1'b0;
            error_q  <= 1'b0;
        end
        else
        begin
            state    <= state_next;
            pc       <= pc_next;
            ptr      <= ptr_next;
            accept_q <= accept_next;
            error_q  <= error_next;
        end
    end

    // run operands captured when needed
    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && start_valid)
        begin
            end_q <= end_ptr;
        end
        if (state == ST_WAIT_INSTR)
        begin
            ch_q <= instr_ch;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_next  = state;
        pc_next     = pc;
        ptr_next    = ptr;
        accept_next = accept_q;
        error_next  = error_q;

        case (state)
            ST_IDLE:
            begin
                if (start_valid)
                begin
                    pc_next     = '0;
                    ptr_next    = start_ptr;
                    accept_next = 1'b0;
                    error_next  = 1'b0;
                    state_next  = ST_FETCH_INSTR;
                end
            end
            ST_FETCH_INSTR, ST_FETCH_CHAR:
            begin
                // request held until granted
                if (mem_req_ready)
                begin
                    state_next = (state == ST_FETCH_INSTR) ? ST_WAIT_INSTR : ST_WAIT_CHAR;
                end
            end
            ST_WAIT_INSTR:
            begin
                state_next = ST_FINISH;
                case (op)
                    regex_pkg::OP_CHAR:
                    begin
                        if (!at_end)
                        begin
                            state_next = ST_FETCH_CHAR;
                        end
                    end
                    regex_pkg::OP_ANY:
                    begin
                        if (!at_end && &pc)
                        begin
                            error_next = 1'b1;
                        end
                        else if (!at_end)
                        begin
                            pc_next    = pc + 1'b1;
                            ptr_next   = ptr + 1'b1;
                            state_next = ST_FETCH_INSTR;
                        end
                    end
                    regex_pkg::OP_ACCEPT:
                    begin
                        accept_next = at_end;
                    end
                    default:
                    begin
                        error_next = 1'b1;
                    end
                endcase
            end
            ST_WAIT_CHAR:
            begin
                state_next = ST_FINISH;
                if (text_ch == ch_q)
                begin
                    // pc past the last word is an error
                    if (&pc)
                    begin
                        error_next = 1'b1;
                    end
                    else
                    begin
                        pc_next    = pc + 1'b1;
                        ptr_next   = ptr + 1'b1;
                        state_next = ST_FETCH_INSTR;
                    end
                end
            end
            ST_FINISH:
            begin
                state_next = ST_IDLE;
            end
            default:
            begin
                state_next = ST_IDLE;
            end
        endcase
    end

    // outputs
    assign start_ready   = (state == ST_IDLE);
    assign mem_req_valid = (state == ST_FETCH_INSTR) || (state == ST_FETCH_CHAR);
    assign mem_req_addr  = (state == ST_FETCH_CHAR) ? ptr[`REGEX_PTR_WIDTH-1:LANE_BITS] : pc;

    assign result.done   = (state == ST_FINISH);
    assign result.accept = (state == ST_FINISH) && accept_q;
    assign result.error  = (state == ST_FINISH) && error_q;

endmodule

/* logic/regex_cmd_ctrl.sv */
// Command decoder and status block of the accelerator.
// Turns the host's level commands into memory accesses and a start request,
// keeps the status and the elapsed-cycle counter, and hands the memory read
// port to the coprocessor while a match runs.

`include "regex_config.svh"

module regex_cmd_ctrl
(
    input  logic                                clk,
    input  logic                                rst_master,
    input  regex_pkg::host_regs_t               host,
    input  logic [`REGEX_MEM_RD_WIDTH-1:0]      rd_data,
    output regex_pkg::mem_wr_t                  mem_wr,
    output regex_pkg::mem_rd_t                  mem_rd,
    output logic                                start_valid,
    input  logic                                start_ready,
    input  logic                                mem_req_valid,
    input  logic [`REGEX_MEM_RD_ADDR_WIDTH-1:0] mem_req_addr,
    output logic                                mem_req_ready,
    input  regex_pkg::match_result_t            result,
    output regex_pkg::regex_status_e            status,
    output logic [`REGEX_REG_WIDTH-1:0]         data_out,
    output logic                                core_rst
);

    localparam int W = `REGEX_REG_WIDTH;

    regex_pkg::regex_status_e status_next;
    logic [W-1:0]             elapsed;
    logic [W-1:0]             elapsed_next;

    // soft reset command behaves like the external reset
    assign core_rst = rst_master || (host.cmd == regex_pkg::CMD_RESET);

    //////////////////////////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (core_rst)
        begin
            status  <= regex_pkg::STATUS_IDLE;
            elapsed <= '0;
        end
        else
        begin
            status  <= status_next;
            elapsed <= elapsed_next;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // command decode and memory ownership
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        status_next   = status;
        elapsed_next  = elapsed;
        data_out      = '0;
        mem_wr        = '0;
        mem_rd        = '0;
        mem_req_ready = 1'b0;
        start_valid   = 1'b0;

        case (status)
            regex_pkg::STATUS_IDLE,
            regex_pkg::STATUS_ACCEPTED,
            regex_pkg::STATUS_REJECTED,
            regex_pkg::STATUS_ERROR:
            begin
                case (host.cmd)
                    regex_pkg::CMD_WRITE:
                    begin
                        mem_wr.en   = 1'b1;
                        mem_wr.addr = host.address[`REGEX_MEM_WR_ADDR_WIDTH-1:0];
                        mem_wr.data = host.data_in[`REGEX_MEM_WR_WIDTH-1:0];
                    end
                    regex_pkg::CMD_READ:
                    begin
                        // upper bits pick the word, bit 0 the 32-bit lane
                        mem_rd.en   = 1'b1;
                        mem_rd.addr = host.address[`REGEX_MEM_RD_ADDR_WIDTH:1];
                        data_out    = rd_data[host.address[0]*W +: W];
                    end
                    regex_pkg::CMD_READ_ELAPSED_CLOCK:
                    begin
                        data_out = elapsed;
                    end
                    regex_pkg::CMD_START:
                    begin
                        // only honoured from idle; a finished run needs restart
                        if (status == regex_pkg::STATUS_IDLE)
                        begin
                            start_valid   = 1'b1;
                            mem_req_ready = 1'b1;
                            mem_rd.en     = mem_req_valid;
                            mem_rd.addr   = mem_req_addr;
                            if (start_ready)
                            begin
                                status_next  = regex_pkg::STATUS_RUNNING;
                                elapsed_next = '0;
                            end
                        end
                    end
                    regex_pkg::CMD_RESTART:
                    begin
                        status_next = regex_pkg::STATUS_IDLE;
                    end
                    default:
                    begin
                        status_next = status;
                    end
                endcase
            end
            regex_pkg::STATUS_RUNNING:
            begin
                // coprocessor owns the read port
                mem_req_ready = 1'b1;
                mem_rd.en     = mem_req_valid;
                mem_rd.addr   = mem_req_addr;

                if (result.done)
                begin
                    if (result.error)
                    begin
                        status_next = regex_pkg::STATUS_ERROR;
                    end
                    else if (result.accept)
                    begin
                        status_next = regex_pkg::STATUS_ACCEPTED;
                    end
                    else
                    begin
                        status_next = regex_pkg::STATUS_REJECTED;
                    end
                end

                // saturating cycle count
                if (!(&elapsed))
                begin
                    elapsed_next = elapsed + 1'b1;
                end
            end
            default:
            begin
                status_next = regex_pkg::STATUS_IDLE;
            end
        endcase
    end

endmodule

/* logic/dual_width_bram.sv */
// Shared program and text memory.
// Written 32 bits at a time from the host side, read 64 bits at a time
// through a registered port by either the host or the coprocessor.

`include "regex_config.svh"

module dual_width_bram
(
    input  logic                           clk,
    input  regex_pkg::mem_wr_t             wr,
    input  regex_pkg::mem_rd_t             rd,
    output logic [`REGEX_MEM_RD_WIDTH-1:0] rd_data
);

    localparam int DEPTH = 2 ** `REGEX_MEM_RD_ADDR_WIDTH;
    localparam int HALF  = `REGEX_MEM_WR_WIDTH;

    logic [`REGEX_MEM_RD_WIDTH-1:0] mem [DEPTH];

    // bit 0 of a write address picks the half of this word
    logic [`REGEX_MEM_RD_ADDR_WIDTH-1:0] wr_word;

    assign wr_word = wr.addr[`REGEX_MEM_WR_ADDR_WIDTH-1:1];

    always_ff @(posedge clk)
    begin
        if (wr.en)
        begin
            if (wr.addr[0])
            begin
                mem[wr_word][HALF +: HALF] <= wr.data;
            end
            else
            begin
                mem[wr_word][0 +: HALF] <= wr.data;
            end
        end
    end

    // registered read that holds its output while not enabled
    always_ff @(posedge clk)
    begin
        if (rd.en)
        begin
            rd_data <= mem[rd.addr];
        end
    end

endmodule

/* logic/regex_pkg.sv */
// Types shared by the regex accelerator: host commands, status codes,
// coprocessor opcodes and the structs that carry the memory ports.
// Refer to items by scoped name, e.g. regex_pkg::host_regs_t.

`include "regex_config.svh"

package regex_pkg;

    // host commands in reference encoding
    typedef enum logic [`REGEX_REG_WIDTH-1:0] {
        CMD_NOP                = 0,
        CMD_WRITE              = 1,
        CMD_READ               = 2,
        CMD_START              = 3,
        CMD_RESET              = 4,
        CMD_READ_ELAPSED_CLOCK = 5,
        CMD_RESTART            = 6
    } regex_cmd_e;

    // status codes seen by the host
    typedef enum logic [`REGEX_REG_WIDTH-1:0] {
        STATUS_IDLE     = 0,
        STATUS_RUNNING  = 1,
        STATUS_ACCEPTED = 2,
        STATUS_REJECTED = 3,
        STATUS_ERROR    = 4
    } regex_status_e;

    // opcode byte in instruction bits 31:24
    typedef enum logic [7:0] {
        OP_CHAR   = 8'h01,
        OP_ANY    = 8'h02,
        OP_ACCEPT = 8'h03
    } regex_op_e;

    typedef struct packed {
        logic [`REGEX_REG_WIDTH-1:0] data_in;
        logic [`REGEX_REG_WIDTH-1:0] address;
        logic [`REGEX_REG_WIDTH-1:0] start_ptr;
        logic [`REGEX_REG_WIDTH-1:0] end_ptr;
        regex_cmd_e                  cmd;
    } host_regs_t;

    typedef struct packed {
        logic                                en;
        logic [`REGEX_MEM_WR_ADDR_WIDTH-1:0] addr;
        logic [`REGEX_MEM_WR_WIDTH-1:0]      data;
    } mem_wr_t;

    typedef struct packed {
        logic                                en;
        logic [`REGEX_MEM_RD_ADDR_WIDTH-1:0] addr;
    } mem_rd_t;

    typedef struct packed {
        logic done;
        logic accept;
        logic error;
    } match_result_t;

endpackage

/* logic/regex_config.svh */
// Width definitions shared by the regex accelerator RTL.
// Include this header wherever one of the widths is needed.

`ifndef REGEX_CONFIG_SVH
`define REGEX_CONFIG_SVH

// host register width
`define REGEX_REG_WIDTH 32

// instruction word address width
`define REGEX_PC_WIDTH 9

// memory port widths
`define REGEX_MEM_RD_WIDTH 64
`define REGEX_MEM_WR_WIDTH 32
`define REGEX_MEM_RD_ADDR_WIDTH `REGEX_PC_WIDTH
`define REGEX_MEM_WR_ADDR_WIDTH (`REGEX_PC_WIDTH + 1)

// text characters and byte pointers
`define REGEX_CHAR_WIDTH 8
`define REGEX_PTR_WIDTH (`REGEX_PC_WIDTH + 3)

`endif
